// ==== list.f ====
mult_pkg.sv
wallace_pkg.sv
partial_product_gen.sv
wallace_stage.sv
wallace_tree.sv
cla_adder.sv
wallace_mult.sv
tb_wallace_mult.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# A failing check ends the run through $fatal, which gives a nonzero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_wallace_mult \
    --Mdir obj_dir \
    -o tb_wallace_mult \
    -f list.f

./obj_dir/tb_wallace_mult

// ==== tb_wallace_mult.sv ====
`timescale 1ns/100ps

module tb_wallace_mult
    import mult_pkg::*;
();

    localparam int WIDTH        = 8;
    localparam int PW           = prod_width(WIDTH);
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 3;
    localparam int DRAIN_CYCLES = 5;
    localparam int PHASE_COUNT  = 4;
    localparam int CORNER_COUNT = 8;
    localparam int WALK_COUNT   = WIDTH * WIDTH;
    localparam int STREAM_COUNT = 300;
    localparam int GAP_COUNT    = 200;
    localparam int VECTOR_COUNT = RESET_CYCLES + CORNER_COUNT + WALK_COUNT + STREAM_COUNT
                                + GAP_COUNT + PHASE_COUNT * DRAIN_CYCLES;
    localparam int TIMEOUT_NS   = VECTOR_COUNT * CLK_PERIOD + 200;

    localparam logic [15:0]      LFSR_SEED = 16'd50;
    localparam logic [15:0]      LFSR_TAPS = 16'hB400; // x^16 + x^14 + x^13 + x^11 + 1.
    localparam logic [WIDTH-1:0] ALL_ONES  = {WIDTH{1'b1}};
    localparam logic [WIDTH-1:0] TOP_BIT   = WIDTH'(1) << (WIDTH - 1);

    logic             clk = 1'b0; // Starts low so that no clock edge falls at time 0.
    logic             rst_n;
    logic             in_valid;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic             out_valid;
    logic [PW-1:0]    product;

    logic [15:0]   lfsr_state;
    logic [2:0]    exp_valid;
    logic [PW-1:0] exp_pipe [3]; // Entry 2 is the product the DUT should show.
    int            accepted  = 0;
    int            delivered = 0;

    wallace_mult #(
        .WIDTH (WIDTH)
    ) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .product   (product)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------
    // Helpers
    // --------------------

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit taken.
    task automatic take_bits(input int count, output logic [PW-1:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[PW-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "Stopping at the first mismatch.");
    endtask

    task automatic drive_cycle(input logic valid, input logic [WIDTH-1:0] x,
                               input logic [WIDTH-1:0] y);
        @(posedge clk);
        in_valid <= valid;
        a        <= x;
        b        <= y;
    endtask

    task automatic drain();
        repeat (DRAIN_CYCLES) begin
            drive_cycle(1'b0, '0, '0);
        end
    endtask

    // --------------------
    // Reference model
    // --------------------

    // Each accepted pair moves one step per edge. The output entry holds between results.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_valid   <= '0;
            exp_pipe[0] <= '0;
            exp_pipe[1] <= '0;
            exp_pipe[2] <= '0;
        end else begin
            exp_valid <= {exp_valid[1:0], in_valid};
            if (in_valid) begin
                exp_pipe[0] <= PW'(a) * PW'(b);
                accepted    <= accepted + 1;
            end
            if (exp_valid[0]) begin
                exp_pipe[1] <= exp_pipe[0];
            end
            if (exp_valid[1]) begin
                exp_pipe[2] <= exp_pipe[1];
            end
        end
    end

    // --------------------
    // Checks
    // --------------------

    // Outputs are settled half a cycle after the edge that changes them.
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (out_valid === 1'b0)
                else report_error("out_valid is high while reset is asserted");
        end
        assert (out_valid === exp_valid[2])
            else report_error($sformatf("out_valid is %0b, expected %0b",
                                        out_valid, exp_valid[2]));
        assert (product === exp_pipe[2])
            else report_error($sformatf("product is %0d, expected %0d (out_valid %0b)",
                                        product, exp_pipe[2], out_valid));
        if (out_valid) begin
            delivered++;
        end
    end

    // --------------------
    // Stimulus
    // --------------------

    initial begin
        logic [PW-1:0] bits;
        logic [PW-1:0] gap;

        rst_n      = 1'b0;
        in_valid   = 1'b0;
        a          = '0;
        b          = '0;
        lfsr_state = LFSR_SEED;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Corner operands. 255 x 255 runs the longest carry chain.
        drive_cycle(1'b1, '0, '0);
        drive_cycle(1'b1, '0, ALL_ONES);
        drive_cycle(1'b1, WIDTH'(1), '0);
        drive_cycle(1'b1, WIDTH'(1), WIDTH'(1));
        drive_cycle(1'b1, WIDTH'(1), WIDTH'(8'h5a));
        drive_cycle(1'b1, WIDTH'(1), ALL_ONES);
        drive_cycle(1'b1, ALL_ONES, ALL_ONES);
        drive_cycle(1'b1, TOP_BIT, TOP_BIT);
        drain();

        for (int i = 0; i < WIDTH; i++) begin // Every row alignment.
            for (int j = 0; j < WIDTH; j++) begin
                drive_cycle(1'b1, WIDTH'(1) << i, WIDTH'(1) << j);
            end
        end
        drain();

        // Back to back, so three pairs are always in flight.
        repeat (STREAM_COUNT) begin
            take_bits(PW, bits);
            drive_cycle(1'b1, bits[PW-1:WIDTH], bits[WIDTH-1:0]);
        end
        drain();

        // Idle cycles still carry random operands, which the DUT must ignore.
        repeat (GAP_COUNT) begin
            take_bits(1, gap);
            take_bits(PW, bits);
            drive_cycle(gap[0], bits[PW-1:WIDTH], bits[WIDTH-1:0]);
        end
        drain();

        if (delivered == accepted && accepted > 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Got %0d results for %0d accepted pairs.", delivered, accepted);
            $display("Checks failed");
            $fatal(1, "Result count does not match the accepted count.");
        end
    end

    // --------------------
    // Watchdog
    // --------------------

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns.", TIMEOUT_NS);
        $display("Checks failed");
        $fatal(1, "Watchdog expired.");
    end

endmodule

// ==== wallace_mult.sv ====
`timescale 1ns/100ps

module wallace_mult import mult_pkg::*; #(
    parameter int WIDTH = DEFAULT_WIDTH
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic [WIDTH-1:0]             a,
    input  logic [WIDTH-1:0]             b,
    output logic                         out_valid,
    output logic [prod_width(WIDTH)-1:0] product
);

    localparam int PW        = prod_width(WIDTH);
    localparam int CLA_GROUP = 4;

    logic [2:0]       valid_pipe; // One bit per register stage.
    logic [WIDTH-1:0] a_q;
    logic [WIDTH-1:0] b_q;
    logic [PW-1:0]    pp_rows [WIDTH];
    logic [PW-1:0]    tree_sum;
    logic [PW-1:0]    tree_carry;
    logic [PW-1:0]    sum_q;
    logic [PW-1:0]    carry_q;
    logic [PW-1:0]    cla_sum;

    // --------------------
    // Valid pipeline
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[1:0], in_valid};
        end
    end

    assign out_valid = valid_pipe[2];

    // --------------------
    // Operand register
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_q <= '0;
            b_q <= '0;
        end else if (in_valid) begin
            a_q <= a;
            b_q <= b;
        end
    end

    partial_product_gen #(
        .WIDTH (WIDTH)
    ) u_pp (
        .a    (a_q),
        .b    (b_q),
        .rows (pp_rows)
    );

    wallace_tree #(
        .WIDTH (WIDTH)
    ) u_tree (
        .rows      (pp_rows),
        .sum_row   (tree_sum),
        .carry_row (tree_carry)
    );

    // Cut between the tree and the adder, which keeps the long carry path on its own cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_q   <= '0;
            carry_q <= '0;
        end else if (valid_pipe[0]) begin
            sum_q   <= tree_sum;
            carry_q <= tree_carry;
        end
    end

    cla_adder #(
        .WIDTH (WIDTH),
        .GROUP (CLA_GROUP)
    ) u_cla (
        .x   (sum_q),
        .y   (carry_q),
        .sum (cla_sum)
    );

    // The product holds its last result between valid cycles.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            product <= '0;
        end else if (valid_pipe[1]) begin
            product <= cla_sum;
        end
    end

endmodule

// ==== cla_adder.sv ====
`timescale 1ns/100ps

module cla_adder import mult_pkg::*; #(
    parameter int WIDTH = DEFAULT_WIDTH,
    parameter int GROUP = 4
) (
    input  logic [prod_width(WIDTH)-1:0] x,
    input  logic [prod_width(WIDTH)-1:0] y,
    output logic [prod_width(WIDTH)-1:0] sum
);

    localparam int PW     = prod_width(WIDTH);
    localparam int GROUPS = (PW + GROUP - 1) / GROUP;
    localparam int PADW   = GROUPS * GROUP;

    logic [PADW-1:0] x_pad;
    logic [PADW-1:0] y_pad;
    logic [PADW-1:0] gen;
    logic [PADW-1:0] prop;
    logic [PADW:0]   carry; // carry[i] enters bit i.

    // Carries into bits 1 to GROUP of one group, written out as sums of products.
    // No carry inside the group waits on the carry below it.
    function automatic logic [GROUP:1] group_carries(
        input logic [GROUP-1:0] g,
        input logic [GROUP-1:0] p,
        input logic             cin
    );
        logic [GROUP:1] c;
        logic           term;
        for (int k = 1; k <= GROUP; k++) begin
            term = cin;
            for (int j = 0; j < k; j++) begin
                term = term & p[j];
            end
            c[k] = term;
            for (int j = 0; j < k; j++) begin
                term = g[j];
                for (int m = j + 1; m < k; m++) begin
                    term = term & p[m];
                end
                c[k] = c[k] | term;
            end
        end
        return c;
    endfunction

    assign x_pad = PADW'(x);
    assign y_pad = PADW'(y);
    assign gen   = x_pad & y_pad;
    assign prop  = x_pad ^ y_pad;

    assign carry[0] = 1'b0;

    // --------------------
    // Lookahead groups
    // --------------------

    // The group carry-out ripples into the next group.
    for (genvar grp = 0; grp < GROUPS; grp++) begin : g_group
        localparam int BASE = grp * GROUP;

        assign carry[BASE+GROUP:BASE+1] =
            group_carries(gen[BASE +: GROUP], prop[BASE +: GROUP], carry[BASE]);
    end

    // The carry out of the top bit is dropped. A product never overflows.
    assign sum = prop[PW-1:0] ^ carry[PW-1:0];

endmodule

// ==== wallace_tree.sv ====
`timescale 1ns/100ps

module wallace_tree import mult_pkg::*, wallace_pkg::*; #(
    parameter int WIDTH = DEFAULT_WIDTH
) (
    input  logic [prod_width(WIDTH)-1:0] rows [WIDTH],
    output logic [prod_width(WIDTH)-1:0] sum_row,
    output logic [prod_width(WIDTH)-1:0] carry_row
);

    localparam int PW         = prod_width(WIDTH);
    localparam int NUM_STAGES = num_stages(WIDTH);
    localparam int ROW_SLOTS  = MAX_ROWS(WIDTH);

    // Row sets between the levels.
    // Slots above a level's row count are tied to zero.
    logic [PW-1:0] level [NUM_STAGES+1][ROW_SLOTS];

    for (genvar r = 0; r < WIDTH; r++) begin : g_entry
        assign level[0][r] = rows[r];
    end

    // --------------------
    // Carry-save levels
    // --------------------

    for (genvar s = 0; s < NUM_STAGES; s++) begin : g_level
        localparam int RIN  = stage_rows(WIDTH, s);
        localparam int ROUT = rows_after(RIN);

        logic [PW-1:0] stage_in  [RIN];
        logic [PW-1:0] stage_out [ROUT];

        for (genvar r = 0; r < RIN; r++) begin : g_in
            assign stage_in[r] = level[s][r];
        end

        wallace_stage #(
            .WIDTH   (WIDTH),
            .ROWS_IN (RIN)
        ) u_stage (
            .rows_in  (stage_in),
            .rows_out (stage_out)
        );

        for (genvar r = 0; r < ROW_SLOTS; r++) begin : g_out
            if (r < ROUT) begin : g_used
                assign level[s+1][r] = stage_out[r];
            end else begin : g_idle
                assign level[s+1][r] = '0;
            end
        end
    end

    // The last level always compresses three rows, so slot 0 holds the sum.
    assign sum_row   = level[NUM_STAGES][0];
    assign carry_row = level[NUM_STAGES][1];

endmodule

// ==== wallace_stage.sv ====
`timescale 1ns/100ps

module wallace_stage import mult_pkg::*, wallace_pkg::*; #(
    parameter int WIDTH   = DEFAULT_WIDTH,
    parameter int ROWS_IN = 3
) (
    input  logic [prod_width(WIDTH)-1:0] rows_in  [ROWS_IN],
    output logic [prod_width(WIDTH)-1:0] rows_out [rows_after(ROWS_IN)]
);

    localparam int PW       = prod_width(WIDTH);
    localparam int GROUPS   = ROWS_IN / 3;
    localparam int LEFTOVER = ROWS_IN % 3;

    // --------------------
    // Full-adder arrays
    // --------------------

    // Each group of three rows goes through one column of full adders per bit.
    // The sum stays in place and the carry moves up one column.
    for (genvar g = 0; g < GROUPS; g++) begin : g_csa
        logic [PW-1:0] x;
        logic [PW-1:0] y;
        logic [PW-1:0] z;
        logic [PW-1:0] majority;

        assign x = rows_in[3*g];
        assign y = rows_in[3*g+1];
        assign z = rows_in[3*g+2];

        assign majority = (x & y) | (x & z) | (y & z);

        assign rows_out[2*g]   = x ^ y ^ z;
        assign rows_out[2*g+1] = {majority[PW-2:0], 1'b0}; // Top carry is always zero.
    end

    // --------------------
    // Leftover rows
    // --------------------

    // One or two rows outside a full group wait for the next level.
    // Two of them are not half-added here.
    for (genvar l = 0; l < LEFTOVER; l++) begin : g_pass
        assign rows_out[2*GROUPS+l] = rows_in[3*GROUPS+l];
    end

endmodule

// ==== partial_product_gen.sv ====
`timescale 1ns/100ps

module partial_product_gen import mult_pkg::*; #(
    parameter int WIDTH = DEFAULT_WIDTH
) (
    input  logic [WIDTH-1:0]             a,
    input  logic [WIDTH-1:0]             b,
    output logic [prod_width(WIDTH)-1:0] rows [WIDTH]
);

    localparam int PW = prod_width(WIDTH);

    logic [PW-1:0] a_ext;

    assign a_ext = PW'(a); // Zero extended, so shifted rows keep their upper bits.

    // --------------------
    // AND array
    // --------------------

    // Row i carries weight 2**i.
    // It is placed at its column here, so the tree adds whole rows.
    for (genvar i = 0; i < WIDTH; i++) begin : g_row
        logic [PW-1:0] masked;

        assign masked  = a_ext & {PW{b[i]}};
        assign rows[i] = masked << i;
    end

endmodule

// ==== wallace_pkg.sv ====
package wallace_pkg;

    // --------------------
    // Reduction schedule
    // --------------------

    // One carry-save level turns each full group of three rows into two.
    // Rows left over from the grouping pass through as they are.
    function automatic int rows_after(input int rows_in);
        return (rows_in / 3) * 2 + (rows_in % 3);
    endfunction

    // Rows entering a given level, counted from the first one.
    function automatic int stage_rows(input int width, input int stage);
        int rows;
        rows = width;
        for (int i = 0; i < stage; i++) begin
            rows = rows_after(rows);
        end
        return rows;
    endfunction

    // Levels needed to bring width rows down to a sum and a carry row.
    function automatic int num_stages(input int width);
        int rows;
        int levels;
        rows   = width;
        levels = 0;
        while (rows > 2) begin
            rows   = rows_after(rows);
            levels = levels + 1;
        end
        return levels;
    endfunction

    // No level ever holds more rows than the AND array produces.
    function automatic int MAX_ROWS(input int width);
        return width;
    endfunction

endpackage

// ==== mult_pkg.sv ====
package mult_pkg;

    // --------------------
    // Operand format
    // --------------------

    // Operands are unsigned.
    // The top level uses this width unless it is told otherwise.
    localparam int DEFAULT_WIDTH = 8;

    // --------------------
    // Product format
    // --------------------

    // Two unsigned WIDTH-bit operands give a product below 2**(2*WIDTH).
    // Every partial-product row and the final sum therefore share this width.
    function automatic int prod_width(input int width);
        return 2 * width;
    endfunction

endpackage
